// File: verilog/radio_ctrl_pkg.sv
// Shared widths, stream and setting bus structs, processor states and protocol constants
package radio_ctrl_pkg;

   // Widths that carry a meaning
   typedef logic [63:0] vita_time_t;
   typedef logic [31:0] sid_t;
   typedef logic [11:0] seqnum_t;
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // One word of a packet stream
   typedef struct packed {
      logic [63:0] tdata;
      logic        tlast;
   } axis_word_t;

   // Internal setting bus, single-cycle strobe with no back-pressure
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } setting_bus_t;

   // Command processor states
   typedef enum logic [2:0] {
      HEAD,
      TIME,
      DATA,
      DUMP,
      RESP_HEAD,
      RESP_TIME,
      RESP_DATA
   } rc_state_t;

   // Response header fields
   localparam logic [3:0]  RESP_PKT_TYPE = 4'hE;
   localparam logic [15:0] RESP_LEN      = 16'd24;

   // Setting addresses owned by the timekeeper
   localparam set_addr_t SR_TIME_HI = 8'h80;
   localparam set_addr_t SR_TIME_LO = 8'h81;

endpackage

// File: verilog/cmd_ingress_fifo.sv
// Command ingress FIFO built as a circular buffer with first-word-fall-through output
`timescale 1ns/1ps

module cmd_ingress_fifo
   import radio_ctrl_pkg::*;
#(
   parameter int FIFO_DEPTH = 8
)
(
   input  logic       clk,
   input  logic       reset,
   input  logic       clear,
   input  axis_word_t in_word,
   input  logic       in_tvalid,
   output logic       in_tready,
   output axis_word_t out_word,
   output logic       out_tvalid,
   input  logic       out_tready
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   axis_word_t       mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             wr_en;
   logic             rd_en;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(FIFO_DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign in_tready  = (count != CNT_W'(FIFO_DEPTH));
   assign out_tvalid = (count != '0);
   assign wr_en      = in_tvalid && in_tready;
   assign rd_en      = out_tvalid && out_tready;

   // Head of the buffer is always presented
   assign out_word = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= in_word;
   end

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= next_ptr(wr_ptr);
         if (rd_en)
            rd_ptr <= next_ptr(rd_ptr);
         if (wr_en && !rd_en)
            count <= count + 1'b1;
         else if (rd_en && !wr_en)
            count <= count - 1'b1;
      end
   end

   // Occupancy never climbs past the depth
   a_no_write_full: assert property (@(posedge clk) disable iff (reset)
      count <= CNT_W'(FIFO_DEPTH));

   // An empty buffer has its read pointer level with the write pointer
   a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
      count == '0 |-> rd_ptr == wr_ptr);

endmodule

// File: verilog/radio_ctrl_proc.sv
// Command processor: header parse, time gate, setting issue and response packet
`timescale 1ns/1ps

module radio_ctrl_proc
   import radio_ctrl_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         clear,
   input  axis_word_t   cmd,
   input  logic         cmd_tvalid,
   output logic         cmd_tready,
   output axis_word_t   resp,
   output logic         resp_tvalid,
   input  logic         resp_tready,
   input  vita_time_t   vita_time,
   input  logic [63:0]  readback,
   output setting_bus_t set_bus
);

   rc_state_t  state;
   seqnum_t    seqnum;
   sid_t       sid;
   vita_time_t resp_time;
   logic       send_resp;
   logic       is_ec;
   logic       has_time;
   logic       go;
   logic       cmd_fire;
   logic       resp_fire;

   // Header flags, only meaningful while in HEAD
   assign is_ec    = (cmd.tdata[63:62] == 2'b10);
   assign has_time = cmd.tdata[61];

   // Requested time reached or already passed
   assign go = (vita_time >= vita_time_t'(cmd.tdata));

   assign cmd_fire  = cmd_tvalid && cmd_tready;
   assign resp_fire = resp_tvalid && resp_tready;

   always_comb
   begin
      case (state)
         HEAD, DATA, DUMP:
            cmd_tready = 1'b1;
         // Time word waits at the FIFO head until its time comes
         TIME:
            cmd_tready = go || cmd.tlast;
         default:
            cmd_tready = 1'b0;
      endcase
   end

   // Setting goes out in the same cycle the data word is taken
   assign set_bus.stb  = (state == DATA) && cmd_tvalid;
   assign set_bus.addr = cmd.tdata[39:32];
   assign set_bus.data = cmd.tdata[31:0];

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         state     <= HEAD;
         send_resp <= 1'b0;
      end
      else
      begin
         case (state)
            HEAD:
               if (cmd_fire)
               begin
                  send_resp <= 1'b0;
                  // Single-word and non-command packets are dropped without an answer
                  if (cmd.tlast)
                     state <= HEAD;
                  else if (!is_ec)
                     state <= DUMP;
                  else if (has_time)
                     state <= TIME;
                  else
                     state <= DATA;
               end
            TIME:
               if (cmd_fire)
                  state <= cmd.tlast ? HEAD : DATA;
            DATA:
               if (cmd_fire)
               begin
                  if (cmd.tlast)
                     state <= RESP_HEAD;
                  else
                  begin
                     send_resp <= 1'b1;
                     state     <= DUMP;
                  end
               end
            DUMP:
               if (cmd_fire && cmd.tlast)
                  state <= send_resp ? RESP_HEAD : HEAD;
            RESP_HEAD:
               if (resp_fire)
                  state <= RESP_TIME;
            RESP_TIME:
               if (resp_fire)
                  state <= RESP_DATA;
            RESP_DATA:
               if (resp_fire)
                  state <= HEAD;
            default:
               state <= HEAD;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == HEAD && cmd_fire)
      begin
         seqnum <= cmd.tdata[59:48];
         sid    <= cmd.tdata[31:0];
      end
      // Time of the first RESP_TIME cycle, held through any stall
      if (state == RESP_HEAD && resp_fire)
         resp_time <= vita_time + 64'd1;
   end

   always_comb
   begin
      resp_tvalid = 1'b1;
      resp.tlast  = 1'b0;
      case (state)
         RESP_HEAD:
            resp.tdata = {RESP_PKT_TYPE, seqnum, RESP_LEN, sid[15:0], sid[31:16]};
         RESP_TIME:
            resp.tdata = resp_time;
         RESP_DATA:
         begin
            resp.tdata = readback;
            resp.tlast = 1'b1;
         end
         default:
         begin
            resp.tdata  = '0;
            resp_tvalid = 1'b0;
         end
      endcase
   end

   // A setting strobe always leads on to a response or a drain
   a_stb_in_data: assert property (@(posedge clk) disable iff (reset)
      set_bus.stb && !clear |=> state == RESP_HEAD || state == DUMP);

   // A stalled response word holds until the far side takes it
   a_resp_hold: assert property (@(posedge clk) disable iff (reset)
      resp_tvalid && !resp_tready && !clear |=> resp_tvalid && $stable(resp));

endmodule

// File: verilog/setting_regs.sv
// Settable register bank with readback of the last written address and value
`timescale 1ns/1ps

module setting_regs
   import radio_ctrl_pkg::*;
#(
   parameter int NUM_REGS = 16
)
(
   input  logic                     clk,
   input  logic                     reset,
   input  setting_bus_t             set_bus,
   output set_data_t [NUM_REGS-1:0] radio_regs,
   output logic [63:0]              readback
);

   localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

   set_addr_t last_addr;
   set_data_t last_value;
   logic      wr_in_range;
   logic      last_in_range;

   assign wr_in_range = (32'(set_bus.addr) < NUM_REGS);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         radio_regs <= '0;
         last_addr  <= '0;
      end
      else if (set_bus.stb)
      begin
         // Out-of-range writes still move the readback address
         last_addr <= set_bus.addr;
         if (wr_in_range)
            radio_regs[set_bus.addr[IDX_W-1:0]] <= set_bus.data;
      end
   end

   assign last_in_range = (32'(last_addr) < NUM_REGS);
   assign last_value    = last_in_range ? radio_regs[last_addr[IDX_W-1:0]] : '0;

   // Upper 24 bits are zero
   assign readback = {24'd0, last_addr, last_value};

   // Readback reflects a write by the following cycle
   a_readback_follows: assert property (@(posedge clk) disable iff (reset)
      set_bus.stb |=> readback[39:32] == $past(set_bus.addr) &&
         readback[31:0] == ($past(wr_in_range) ? $past(set_bus.data) : 32'd0));

endmodule

// File: verilog/vita_timekeeper.sv
// Free-running radio time counter, loaded through the reserved time addresses
`timescale 1ns/1ps

module vita_timekeeper
   import radio_ctrl_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  setting_bus_t set_bus,
   output vita_time_t   vita_time
);

   set_data_t time_hi;
   logic      load_hi;
   logic      load_lo;

   assign load_hi = set_bus.stb && (set_bus.addr == SR_TIME_HI);
   assign load_lo = set_bus.stb && (set_bus.addr == SR_TIME_LO);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         time_hi   <= '0;
         vita_time <= '0;
      end
      else
      begin
         // High half waits here until the low half arrives
         if (load_hi)
            time_hi <= set_bus.data;
         if (load_lo)
            vita_time <= {time_hi, set_bus.data};
         else
            vita_time <= vita_time + 64'd1;
      end
   end

endmodule

// File: verilog/radio_ctrl_top.sv
// Radio control endpoint top level: ingress FIFO, processor, register bank, timekeeper
`timescale 1ns/1ps

module radio_ctrl_top
   import radio_ctrl_pkg::*;
#(
   parameter int FIFO_DEPTH = 8,
   parameter int NUM_REGS   = 16
)
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     clear,
   input  axis_word_t               ctrl_in,
   input  logic                     ctrl_tvalid,
   output logic                     ctrl_tready,
   output axis_word_t               resp,
   output logic                     resp_tvalid,
   input  logic                     resp_tready,
   output set_data_t [NUM_REGS-1:0] radio_regs,
   output vita_time_t               vita_time
);

   axis_word_t   cmd;
   logic         cmd_tvalid;
   logic         cmd_tready;
   setting_bus_t set_bus;
   logic [63:0]  readback;

   cmd_ingress_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clk        (clk),
      .reset      (reset),
      .clear      (clear),
      .in_word    (ctrl_in),
      .in_tvalid  (ctrl_tvalid),
      .in_tready  (ctrl_tready),
      .out_word   (cmd),
      .out_tvalid (cmd_tvalid),
      .out_tready (cmd_tready)
   );

   radio_ctrl_proc u_proc (
      .clk         (clk),
      .reset       (reset),
      .clear       (clear),
      .cmd         (cmd),
      .cmd_tvalid  (cmd_tvalid),
      .cmd_tready  (cmd_tready),
      .resp        (resp),
      .resp_tvalid (resp_tvalid),
      .resp_tready (resp_tready),
      .vita_time   (vita_time),
      .readback    (readback),
      .set_bus     (set_bus)
   );

   setting_regs #(
      .NUM_REGS (NUM_REGS)
   ) u_regs (
      .clk        (clk),
      .reset      (reset),
      .set_bus    (set_bus),
      .radio_regs (radio_regs),
      .readback   (readback)
   );

   vita_timekeeper u_time (
      .clk       (clk),
      .reset     (reset),
      .set_bus   (set_bus),
      .vita_time (vita_time)
   );

endmodule

// File: test/radio_ctrl_tb.sv
// Radio control endpoint testbench with clock, reset, command stimulus, response model and checks
`timescale 1ns/1ps

module radio_ctrl_tb
   import radio_ctrl_pkg::*;
();

   localparam int NUM_REGS = 16;
   // Reset, untimed, format, future, late, time load, discard, back-pressure
   localparam int TEST_CYCLES    = 4 + 12 + 20 + 55 + 12 + 28 + 20 + 72;
   localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES;

   logic                     clk = 1'b0;
   logic                     reset;
   logic                     clear;
   axis_word_t               ctrl_in;
   logic                     ctrl_tvalid;
   logic                     ctrl_tready;
   axis_word_t               resp;
   logic                     resp_tvalid;
   logic                     resp_tready;
   set_data_t [NUM_REGS-1:0] radio_regs;
   vita_time_t               vita_time;

   // Expected response words in order of arrival
   // Time words carry a lower bound instead of an exact value
   logic [63:0] exp_val [256];
   logic        exp_last [256];
   logic        exp_is_time [256];
   logic [7:0]  exp_wr;
   logic [7:0]  exp_rd;
   logic [63:0] exp_word;
   logic        exp_tlast;
   logic        exp_time;
   logic        exp_pending;
   set_data_t   reg_at_exp;

   vita_time_t  model_time;
   vita_time_t  load_val;
   logic        load_arm;
   vita_time_t  gate_time;
   logic        gate_active;
   logic        regs_frozen;
   logic        hold_regs;
   logic        stall_en;
   string       test_name = "reset";
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          cycles = 0;

   radio_ctrl_top #(
      .FIFO_DEPTH (8),
      .NUM_REGS   (NUM_REGS)
   ) dut0 (
      .clk         (clk),
      .reset       (reset),
      .clear       (clear),
      .ctrl_in     (ctrl_in),
      .ctrl_tvalid (ctrl_tvalid),
      .ctrl_tready (ctrl_tready),
      .resp        (resp),
      .resp_tvalid (resp_tvalid),
      .resp_tready (resp_tready),
      .radio_regs  (radio_regs),
      .vita_time   (vita_time)
   );

   always #2 clk = ~clk;

   assign exp_word    = exp_val[exp_rd];
   assign exp_tlast   = exp_last[exp_rd];
   assign exp_time    = exp_is_time[exp_rd];
   assign exp_pending = (exp_wr != exp_rd);
   assign reg_at_exp  = radio_regs[exp_word[35:32]];
   assign hold_regs   = regs_frozen || (gate_active && vita_time < gate_time);

   // Radio time as the timekeeper rules define it
   always @(posedge clk)
   begin
      if (reset)
         model_time <= '0;
      else if (load_arm)
         model_time <= load_val;
      else
         model_time <= model_time + 64'd1;
   end

   always @(posedge clk)
   begin
      if (reset)
         exp_rd <= '0;
      else if (resp_tvalid && resp_tready && exp_pending)
         exp_rd <= exp_rd + 8'd1;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: run exceeded %0d cycles in %s", TIMEOUT_CYCLES, test_name);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   // Each accepted response word matches the model in order
   // A reported time lies between its lower bound and the radio time at acceptance
   a_resp_word: assert property (@(posedge clk) disable iff (reset)
      resp_tvalid && resp_tready |-> exp_pending && resp.tlast == exp_tlast &&
         (exp_time ? (resp.tdata >= exp_word && resp.tdata <= model_time)
                   : resp.tdata == exp_word))
   else
   begin
      errors++;
      if (!$sampled(exp_pending))
         $display("In %s a response word %h arrived with none expected",
            test_name, $sampled(resp.tdata));
      else
         $display("Mismatch in %s: expected %h last %b, actual %h last %b", test_name,
            $sampled(exp_word), $sampled(exp_tlast), $sampled(resp.tdata),
            $sampled(resp.tlast));
   end

   // Written register holds the data once its response ends
   a_reg_value: assert property (@(posedge clk) disable iff (reset)
      resp_tvalid && resp_tready && exp_pending && exp_tlast && exp_word[39:36] == 4'd0
         |-> reg_at_exp == exp_word[31:0])
   else
   begin
      errors++;
      $display("Mismatch in %s: register %0d expected %h, actual %h", test_name,
         $sampled(exp_word[35:32]), $sampled(exp_word[31:0]), $sampled(reg_at_exp));
   end

   a_regs_hold: assert property (@(posedge clk) disable iff (reset)
      hold_regs |=> $stable(radio_regs))
   else
   begin
      errors++;
      $display("In %s the register bank changed while it had to hold", test_name);
   end

   a_resp_stable: assert property (@(posedge clk) disable iff (reset)
      resp_tvalid && !resp_tready |=> resp_tvalid && $stable(resp))
   else
   begin
      errors++;
      $display("In %s a stalled response word changed or was dropped", test_name);
   end

   a_time: assert property (@(posedge clk) disable iff (reset)
      vita_time == model_time)
   else
   begin
      errors++;
      $display("Mismatch in %s: vita_time expected %h, actual %h", test_name,
         $sampled(model_time), $sampled(vita_time));
   end

   // Random stalls on the response side
   initial
   begin
      resp_tready = 1'b1;
      forever
      begin
         @(posedge clk);
         #1;
         resp_tready = stall_en ? 1'($urandom) : 1'b1;
      end
   end

   task automatic put_word(input logic [63:0] data, input logic last);
      ctrl_in.tdata = data;
      ctrl_in.tlast = last;
      ctrl_tvalid   = 1'b1;
      while (!ctrl_tready)
      begin
         @(posedge clk);
         #1;
      end
      @(posedge clk);
      #1;
      ctrl_tvalid = 1'b0;
   endtask

   task automatic expect_word(input logic [63:0] val, input logic is_time, input logic last);
      exp_val[exp_wr]     = val;
      exp_is_time[exp_wr] = is_time;
      exp_last[exp_wr]    = last;
      exp_wr              = exp_wr + 8'd1;
   endtask

   task automatic send_cmd(input logic timed, input vita_time_t when, input set_addr_t addr,
                           input set_data_t data);
      seqnum_t     seq;
      sid_t        sid;
      logic [15:0] len;
      seq = seqnum_t'($urandom);
      sid = $urandom;
      len = timed ? 16'd24 : 16'd16;
      // Header echoes seqnum with the stream ID halves swapped
      expect_word({4'hE, seq, 16'd24, sid[15:0], sid[31:16]}, 1'b0, 1'b0);
      expect_word(timed ? when : 64'd0, 1'b1, 1'b0);
      expect_word({24'd0, addr, (addr < 8'(NUM_REGS)) ? data : 32'd0}, 1'b0, 1'b1);
      put_word({2'b10, timed, 1'b0, seq, len, sid}, 1'b0);
      if (timed)
         put_word(when, 1'b0);
      put_word({24'd0, addr, data}, 1'b1);
   endtask

   task automatic wait_drain();
      while (exp_wr != exp_rd)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic end_test(input int errors_before);
      tests_run++;
      if (errors == errors_before)
         $display("Test %s: passed", test_name);
      else
      begin
         tests_failed++;
         $display("Test %s: failed with %0d errors", test_name, errors - errors_before);
      end
   endtask

   function automatic set_addr_t rand_addr();
      return set_addr_t'($urandom_range(NUM_REGS - 1, 0));
   endfunction

   initial
   begin
      int         errs_at_start;
      set_data_t  hi;
      set_data_t  lo;
      vita_time_t when;
      void'($urandom(32'hdc15d1ad));
      reset       = 1'b1;
      clear       = 1'b0;
      ctrl_in     = '0;
      ctrl_tvalid = 1'b0;
      exp_wr      = '0;
      load_arm    = 1'b0;
      load_val    = '0;
      gate_time   = '0;
      gate_active = 1'b0;
      regs_frozen = 1'b0;
      stall_en    = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;

      test_name     = "untimed_write";
      errs_at_start = errors;
      send_cmd(1'b0, '0, rand_addr(), $urandom);
      wait_drain();
      end_test(errs_at_start);

      test_name     = "response_format";
      errs_at_start = errors;
      send_cmd(1'b0, '0, rand_addr(), $urandom);
      send_cmd(1'b0, '0, rand_addr(), $urandom);
      wait_drain();
      end_test(errs_at_start);

      // Register must hold until the requested time
      test_name     = "future_timed";
      errs_at_start = errors;
      when          = model_time + 64'd40;
      gate_time     = when;
      gate_active   = 1'b1;
      send_cmd(1'b1, when, rand_addr(), $urandom);
      wait_drain();
      gate_active = 1'b0;
      end_test(errs_at_start);

      test_name     = "late_timed";
      errs_at_start = errors;
      send_cmd(1'b1, model_time - 64'd5, rand_addr(), $urandom);
      wait_drain();
      end_test(errs_at_start);

      // Load lands one edge after the low half is written to an idle FIFO
      test_name     = "time_load";
      errs_at_start = errors;
      hi            = $urandom;
      lo            = $urandom;
      send_cmd(1'b0, '0, SR_TIME_HI, hi);
      wait_drain();
      send_cmd(1'b0, '0, SR_TIME_LO, lo);
      load_val = {hi, lo};
      load_arm = 1'b1;
      @(posedge clk);
      #1;
      load_arm = 1'b0;
      wait_drain();
      repeat (5) @(posedge clk);
      #1;
      end_test(errs_at_start);

      test_name     = "discard";
      errs_at_start = errors;
      regs_frozen   = 1'b1;
      put_word({2'b00, 30'd0, 32'($urandom)}, 1'b0);
      put_word({24'd0, rand_addr(), 32'($urandom)}, 1'b0);
      put_word(64'd0, 1'b1);
      repeat (10) @(posedge clk);
      #1;
      regs_frozen = 1'b0;
      end_test(errs_at_start);

      test_name     = "backpressure";
      errs_at_start = errors;
      stall_en      = 1'b1;
      repeat (4) send_cmd(1'b0, '0, rand_addr(), $urandom);
      wait_drain();
      stall_en = 1'b0;
      end_test(errs_at_start);

      $display("Tests run %0d, failed %0d, assertion errors %0d", tests_run, tests_failed,
         errors);
      if (tests_failed == 0 && errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: sim.f
verilog/radio_ctrl_pkg.sv
verilog/cmd_ingress_fifo.sv
verilog/radio_ctrl_proc.sv
verilog/setting_regs.sv
verilog/vita_timekeeper.sv
verilog/radio_ctrl_top.sv
test/radio_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the radio control endpoint testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module radio_ctrl_tb \
   -f sim.f -o radio_ctrl_sim > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/radio_ctrl_sim > sim.log 2>&1 || { cat sim.log; echo "Run failed"; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "Result: FAIL"; exit 1; }
echo "Result: PASS"
exit 0
